/* common/valu_types_pkg.sv */
package valu_types_pkg;

    localparam int DATA_WIDTH = 64;
    localparam int BE_WIDTH   = DATA_WIDTH / 8;
    localparam int ADDR_WIDTH = 32;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [BE_WIDTH-1:0]   be_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [1:0]            sew_t;     // 0:e8 1:e16 2:e32 3:e64
    typedef logic [5:0]            funct_t;
    typedef logic [2:0]            opclass_t;

    typedef struct packed {
        funct_t   funct;
        opclass_t opclass;
        sew_t     sew;
        data_t    data0;      // scalar or first operand
        data_t    data1;      // vector operand
        be_t      be;
        addr_t    addr;
        logic     is_start;
        logic     is_end;
    } valu_req_t;

    typedef struct packed {
        data_t data;
        be_t   be;
        sew_t  sew;
        addr_t addr;
        logic  is_start;
        logic  is_end;
        logic  red;           // scalar reduction result
    } valu_resp_t;

endpackage

/* common/valu_op_pkg.sv */
package valu_op_pkg;

    // major opcode classes
    localparam valu_types_pkg::opclass_t OPCLASS_IV  = 3'd0;
    localparam valu_types_pkg::opclass_t OPCLASS_MV  = 3'd2;
    localparam valu_types_pkg::opclass_t OPCLASS_IVI = 3'd3;
    localparam valu_types_pkg::opclass_t OPCLASS_IX  = 3'd4;

    // funct6, element-wise classes
    localparam valu_types_pkg::funct_t F_ADD  = 6'd0;
    localparam valu_types_pkg::funct_t F_SUB  = 6'd2;
    localparam valu_types_pkg::funct_t F_MINU = 6'd4;
    localparam valu_types_pkg::funct_t F_MIN  = 6'd5;
    localparam valu_types_pkg::funct_t F_MAXU = 6'd6;
    localparam valu_types_pkg::funct_t F_MAX  = 6'd7;
    localparam valu_types_pkg::funct_t F_AND  = 6'd9;
    localparam valu_types_pkg::funct_t F_OR   = 6'd10;
    localparam valu_types_pkg::funct_t F_XOR  = 6'd11;

    // funct6 under OPCLASS_MV
    localparam valu_types_pkg::funct_t F_REDSUM = 6'd0;
    localparam valu_types_pkg::funct_t F_REDAND = 6'd1;
    localparam valu_types_pkg::funct_t F_REDOR  = 6'd2;
    localparam valu_types_pkg::funct_t F_REDXOR = 6'd3;

    typedef enum logic [3:0] {
        OP_ADD, OP_SUB, OP_MINU, OP_MIN, OP_MAXU, OP_MAX,
        OP_AND, OP_OR, OP_XOR,
        RED_SUM, RED_AND, RED_OR, RED_XOR
    } alu_op_t;

    typedef struct packed {
        alu_op_t                 op;
        logic                    is_red;
        valu_types_pkg::sew_t    sew;
        valu_types_pkg::data_t   data0;
        valu_types_pkg::data_t   data1;
        valu_types_pkg::be_t     be;
        valu_types_pkg::addr_t   addr;
        logic                    is_start;
        logic                    is_end;
    } valu_dec_t;

    typedef struct packed {
        valu_types_pkg::data_t   data;
        valu_types_pkg::be_t     be;
        valu_types_pkg::sew_t    sew;
        valu_types_pkg::addr_t   addr;
        logic                    is_start;
        logic                    is_end;
        logic                    red;
    } valu_exec_t;

endpackage

/* rtl/valu_decode.sv */
`timescale 1ns/100ps

module valu_decode (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req_valid,
    input  valu_types_pkg::valu_req_t  req,
    output logic                       dec_valid,
    output valu_op_pkg::valu_dec_t     dec
);

    valu_op_pkg::alu_op_t op_d;
    logic                 is_red_d;
    logic                 ok_d;

    always_comb begin
        op_d     = valu_op_pkg::OP_ADD;
        is_red_d = 1'b0;
        ok_d     = 1'b0;
        case (req.opclass)
            valu_op_pkg::OPCLASS_IV, valu_op_pkg::OPCLASS_IX, valu_op_pkg::OPCLASS_IVI: begin
                ok_d = 1'b1;
                case (req.funct)
                    valu_op_pkg::F_ADD:  op_d = valu_op_pkg::OP_ADD;
                    valu_op_pkg::F_SUB:  op_d = valu_op_pkg::OP_SUB;
                    valu_op_pkg::F_MINU: op_d = valu_op_pkg::OP_MINU;
                    valu_op_pkg::F_MIN:  op_d = valu_op_pkg::OP_MIN;
                    valu_op_pkg::F_MAXU: op_d = valu_op_pkg::OP_MAXU;
                    valu_op_pkg::F_MAX:  op_d = valu_op_pkg::OP_MAX;
                    valu_op_pkg::F_AND:  op_d = valu_op_pkg::OP_AND;
                    valu_op_pkg::F_OR:   op_d = valu_op_pkg::OP_OR;
                    valu_op_pkg::F_XOR:  op_d = valu_op_pkg::OP_XOR;
                    default:             ok_d = 1'b0;
                endcase
            end
            valu_op_pkg::OPCLASS_MV: begin
                ok_d     = 1'b1;
                is_red_d = 1'b1;
                case (req.funct)
                    valu_op_pkg::F_REDSUM: op_d = valu_op_pkg::RED_SUM;
                    valu_op_pkg::F_REDAND: op_d = valu_op_pkg::RED_AND;
                    valu_op_pkg::F_REDOR:  op_d = valu_op_pkg::RED_OR;
                    valu_op_pkg::F_REDXOR: op_d = valu_op_pkg::RED_XOR;
                    default:               ok_d = 1'b0; // element codes under MV too
                endcase
            end
            default: ok_d = 1'b0;
        endcase
    end

    // unsupported beats vanish here
    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= req_valid && ok_d;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            dec.op       <= op_d;
            dec.is_red   <= is_red_d;
            dec.sew      <= req.sew;
            dec.data0    <= req.data0;
            dec.data1    <= req.data1;
            dec.be       <= req.be;
            dec.addr     <= req.addr;
            dec.is_start <= req.is_start;
            dec.is_end   <= req.is_end;
        end
    end

endmodule

/* alu/valu_elem_alu.sv */
`timescale 1ns/100ps

module valu_elem_alu (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       dec_valid,
    input  valu_op_pkg::valu_dec_t     dec,
    output logic                       elem_valid,
    output valu_op_pkg::valu_exec_t    elem
);

    // one full-width result per element width
    wire [valu_types_pkg::DATA_WIDTH-1:0] lane_res [4];
    logic alu_fire;

    assign alu_fire = dec_valid && !dec.is_red;

    for (genvar s = 0; s < 4; s++) begin : g_sew
        localparam int W = 8 << s;

        for (genvar i = 0; i < valu_types_pkg::DATA_WIDTH / W; i++) begin : g_lane
            logic [W-1:0] a;
            logic [W-1:0] b;
            logic [W-1:0] r;
            logic         lt_u;
            logic         lt_s;

            assign a    = dec.data1[i*W +: W];   // vs2
            assign b    = dec.data0[i*W +: W];   // vs1 / rs1 / imm
            assign lt_u = a < b;
            assign lt_s = $signed(a) < $signed(b);

            always_comb begin
                case (dec.op)
                    valu_op_pkg::OP_ADD:  r = a + b;
                    valu_op_pkg::OP_SUB:  r = a - b;
                    valu_op_pkg::OP_MINU: r = lt_u ? a : b;
                    valu_op_pkg::OP_MIN:  r = lt_s ? a : b;
                    valu_op_pkg::OP_MAXU: r = lt_u ? b : a;
                    valu_op_pkg::OP_MAX:  r = lt_s ? b : a;
                    valu_op_pkg::OP_AND:  r = a & b;
                    valu_op_pkg::OP_OR:   r = a | b;
                    valu_op_pkg::OP_XOR:  r = a ^ b;
                    default:              r = '0;
                endcase
            end

            assign lane_res[s][i*W +: W] = r;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            elem_valid <= 1'b0;
        end else begin
            elem_valid <= alu_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_fire) begin
            elem.data     <= lane_res[dec.sew];
            elem.be       <= dec.be;
            elem.sew      <= dec.sew;
            elem.addr     <= dec.addr;
            elem.is_start <= dec.is_start;
            elem.is_end   <= dec.is_end;
            elem.red      <= 1'b0;
        end
    end

    // decode must keep reductions away from this unit
    assert property (@(posedge clk) disable iff (rst)
        elem_valid |-> !($past(dec.op) inside {valu_op_pkg::RED_SUM, valu_op_pkg::RED_AND,
                                               valu_op_pkg::RED_OR, valu_op_pkg::RED_XOR}))
        else $error("elem_valid raised for a reduction op");

endmodule

/* reduce/valu_red_accum.sv */
`timescale 1ns/100ps

module valu_red_accum (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       dec_valid,
    input  valu_op_pkg::valu_dec_t     dec,
    output logic                       red_valid,
    output valu_op_pkg::valu_exec_t    red
);

    typedef enum logic {
        RED_IDLE,
        RED_ACC
    } red_state_t;

    red_state_t            state;
    valu_types_pkg::data_t acc;        // running scalar, zero-extended
    logic                  acc_fire;

    wire [valu_types_pkg::DATA_WIDTH-1:0] fold_res [4];

    assign acc_fire = dec_valid && dec.is_red;

    for (genvar s = 0; s < 4; s++) begin : g_sew
        localparam int W = 8 << s;
        localparam int N = valu_types_pkg::DATA_WIDTH / W;

        logic [W-1:0] seed;
        logic [W-1:0] f;

        // start beat seeds from element 0 of vs1
        assign seed = dec.is_start ? dec.data0[W-1:0] : acc[W-1:0];

        always_comb begin
            f = seed;
            for (int i = 0; i < N; i++) begin
                case (dec.op)
                    valu_op_pkg::RED_SUM: f = f + dec.data1[i*W +: W];
                    valu_op_pkg::RED_AND: f = f & dec.data1[i*W +: W];
                    valu_op_pkg::RED_OR:  f = f | dec.data1[i*W +: W];
                    valu_op_pkg::RED_XOR: f = f ^ dec.data1[i*W +: W];
                    default:              f = f;
                endcase
            end
        end

        assign fold_res[s] = valu_types_pkg::data_t'(f);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= RED_IDLE;
            red_valid <= 1'b0;
        end else begin
            red_valid <= acc_fire && dec.is_end;
            if (acc_fire) begin
                state <= dec.is_end ? RED_IDLE : RED_ACC;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acc_fire) begin
            acc <= fold_res[dec.sew];
        end
        if (acc_fire && dec.is_end) begin
            red.data     <= fold_res[dec.sew];
            // low 1 << sew bytes
            red.be       <= valu_types_pkg::be_t'((9'd1 << (4'd1 << dec.sew)) - 9'd1);
            red.sew      <= dec.sew;
            red.addr     <= dec.addr;
            red.is_start <= dec.is_start;
            red.is_end   <= dec.is_end;
            red.red      <= 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        acc_fire && state == RED_IDLE |-> dec.is_start)
        else $error("reduction beat without start while idle");

    assert property (@(posedge clk) disable iff (rst)
        acc_fire && state == RED_ACC |-> !dec.is_start)
        else $error("new reduction started before the previous one ended");

endmodule

/* rtl/valu_writeback.sv */
`timescale 1ns/100ps

module valu_writeback (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       elem_valid,
    input  valu_op_pkg::valu_exec_t    elem,
    input  logic                       red_valid,
    input  valu_op_pkg::valu_exec_t    red,
    output logic                       resp_valid,
    output valu_types_pkg::valu_resp_t resp
);

    valu_op_pkg::valu_exec_t sel;

    assign sel = elem_valid ? elem : red;   // at most one unit finishes per cycle

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
            resp       <= '0;
        end else begin
            resp_valid <= elem_valid || red_valid;
            if (elem_valid || red_valid) begin
                resp.data     <= sel.data;
                resp.be       <= sel.be;
                resp.sew      <= sel.sew;
                resp.addr     <= sel.addr;
                resp.is_start <= sel.is_start;
                resp.is_end   <= sel.is_end;
                resp.red      <= sel.red;
            end
        end
    end

    // both execute units have the same latency, so no collisions
    assert property (@(posedge clk) disable iff (rst)
        !(elem_valid && red_valid))
        else $error("element and reduction results in the same cycle");

endmodule

/* rtl/valu_top.sv */
`timescale 1ns/100ps

module valu_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req_valid,
    input  valu_types_pkg::valu_req_t  req,
    output logic                       resp_valid,
    output valu_types_pkg::valu_resp_t resp
);

    logic                    dec_valid;
    valu_op_pkg::valu_dec_t  dec;
    logic                    elem_valid;
    valu_op_pkg::valu_exec_t elem;
    logic                    red_valid;
    valu_op_pkg::valu_exec_t red;

    valu_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .dec_valid  (dec_valid),
        .dec        (dec)
    );

    valu_elem_alu u_elem_alu (
        .clk        (clk),
        .rst        (rst),
        .dec_valid  (dec_valid),
        .dec        (dec),
        .elem_valid (elem_valid),
        .elem       (elem)
    );

    valu_red_accum u_red_accum (
        .clk        (clk),
        .rst        (rst),
        .dec_valid  (dec_valid),
        .dec        (dec),
        .red_valid  (red_valid),
        .red        (red)
    );

    valu_writeback u_writeback (
        .clk        (clk),
        .rst        (rst),
        .elem_valid (elem_valid),
        .elem       (elem),
        .red_valid  (red_valid),
        .red        (red),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

endmodule

/* testbench/tb_valu_model.svh */
`ifndef TB_VALU_MODEL_SVH
`define TB_VALU_MODEL_SVH

// x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// expected response for one request, returns 0 when none is due
function automatic bit valu_ref(input valu_types_pkg::valu_req_t r,
                                inout valu_types_pkg::data_t acc,
                                output valu_types_pkg::valu_resp_t e);
    int          w;
    int          i;
    logic [63:0] mask;
    logic [63:0] sgn;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] y;
    w    = 8 << r.sew;
    mask = (w == 64) ? '1 : (64'd1 << w) - 64'd1;
    sgn  = 64'd1 << (w - 1);
    e    = '{data: '0, be: r.be, sew: r.sew, addr: r.addr,
             is_start: r.is_start, is_end: r.is_end, red: 1'b0};
    if (r.opclass inside {valu_op_pkg::OPCLASS_IV, valu_op_pkg::OPCLASS_IX,
                          valu_op_pkg::OPCLASS_IVI} &&
        r.funct inside {valu_op_pkg::F_ADD, valu_op_pkg::F_SUB, valu_op_pkg::F_MINU,
                        valu_op_pkg::F_MIN, valu_op_pkg::F_MAXU, valu_op_pkg::F_MAX,
                        valu_op_pkg::F_AND, valu_op_pkg::F_OR, valu_op_pkg::F_XOR}) begin
        for (i = 0; i < 64 / w; i++) begin
            a = (r.data1 >> (i * w)) & mask;
            b = (r.data0 >> (i * w)) & mask;
            case (r.funct)
                valu_op_pkg::F_ADD:  y = a + b;
                valu_op_pkg::F_SUB:  y = a - b;
                valu_op_pkg::F_MINU: y = (a < b) ? a : b;
                valu_op_pkg::F_MIN:  y = ((a ^ sgn) < (b ^ sgn)) ? a : b; // sign flip
                valu_op_pkg::F_MAXU: y = (a < b) ? b : a;
                valu_op_pkg::F_MAX:  y = ((a ^ sgn) < (b ^ sgn)) ? b : a;
                valu_op_pkg::F_AND:  y = a & b;
                valu_op_pkg::F_OR:   y = a | b;
                default:             y = a ^ b;
            endcase
            e.data = e.data | ((y & mask) << (i * w));
        end
        return 1'b1;
    end
    if (r.opclass != valu_op_pkg::OPCLASS_MV ||
        !(r.funct inside {valu_op_pkg::F_REDSUM, valu_op_pkg::F_REDAND,
                          valu_op_pkg::F_REDOR, valu_op_pkg::F_REDXOR}))
        return 1'b0;
    if (r.is_start)
        acc = r.data0 & mask;   // seed from element 0
    for (i = 0; i < 64 / w; i++) begin
        a = (r.data1 >> (i * w)) & mask;
        case (r.funct)
            valu_op_pkg::F_REDSUM: acc = (acc + a) & mask;
            valu_op_pkg::F_REDAND: acc = acc & a;
            valu_op_pkg::F_REDOR:  acc = acc | a;
            default:               acc = acc ^ a;
        endcase
    end
    e.data = acc;
    e.be   = 8'((16'd1 << (w / 8)) - 16'd1);
    e.red  = 1'b1;
    return r.is_end;
endfunction

task automatic check_val(input string name, input logic [127:0] got,
                         input logic [127:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Error %s: got %0h, expected %0h at cycle %0d", name, got, exp, cyc);
    end
endtask

`endif

/* testbench/tb_valu.sv */
`timescale 1ns/100ps

module tb_valu;

    localparam int RESET_CYCLES = 10;
    localparam int NUM_TESTS    = 7;
    localparam int TOTAL_BEATS  = 32 + 48 + 32 + 40 + 16 + 20;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + TOTAL_BEATS + 12 * NUM_TESTS + 50;

    logic                       clk = 1'b0;
    logic                       rst;
    logic                       req_valid;
    valu_types_pkg::valu_req_t  req;
    logic                       resp_valid;
    valu_types_pkg::valu_resp_t resp;

    int                         cyc = 0;
    int                         errors = 0;
    int                         checks = 0;
    int                         tests_run = 0;
    int                         test_err0 = 0;
    logic [31:0]                lfsr = 32'h1220_a7a3;
    valu_types_pkg::data_t      ref_acc = '0;
    valu_types_pkg::valu_resp_t exp_q [$];
    int                         cyc_q [$];
    valu_types_pkg::valu_resp_t exp_resp;
    int                         exp_cyc;

    valu_types_pkg::funct_t mm_functs [4] = '{valu_op_pkg::F_MINU, valu_op_pkg::F_MIN,
                                              valu_op_pkg::F_MAXU, valu_op_pkg::F_MAX};
    valu_types_pkg::funct_t lg_functs [3] = '{valu_op_pkg::F_AND, valu_op_pkg::F_OR,
                                              valu_op_pkg::F_XOR};
    valu_types_pkg::funct_t red_functs [4] = '{valu_op_pkg::F_REDSUM, valu_op_pkg::F_REDAND,
                                               valu_op_pkg::F_REDOR, valu_op_pkg::F_REDXOR};
    valu_types_pkg::funct_t   bad_functs [8] = '{6'd1, 6'd3, 6'd8, 6'd12, 6'd13, 6'd20,
                                                 6'd31, 6'd63};
    valu_types_pkg::opclass_t bad_classes [4] = '{3'd1, 3'd5, 3'd6, 3'd7};

    `include "tb_valu_model.svh"

    valu_top DUT (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    always #2 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    initial begin
        wait (cyc >= CYCLE_LIMIT);
        $display("timeout after %0d cycles, %0d responses still expected", cyc, exp_q.size());
        $display("tests failed");
        $finish;
    end

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!rst && resp_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("response at cycle %0d while no response was expected", cyc);
            end else begin
                exp_resp = exp_q.pop_front();
                exp_cyc  = cyc_q.pop_front();
                check_val("resp_valid cycle", cyc, exp_cyc);
                check_val("resp.data", resp.data, exp_resp.data);
                check_val("resp.be", resp.be, exp_resp.be);
                check_val("resp.sew", resp.sew, exp_resp.sew);
                check_val("resp.addr", resp.addr, exp_resp.addr);
                check_val("resp.is_start", resp.is_start, exp_resp.is_start);
                check_val("resp.is_end", resp.is_end, exp_resp.is_end);
                check_val("resp.red", resp.red, exp_resp.red);
            end
        end
    end

    task automatic rand_bits(input int n, output logic [63:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v[i] = lfsr[0];
        end
    endtask

    function automatic valu_types_pkg::opclass_t elem_class(input logic [1:0] v);
        case (v)
            2'd0:    return valu_op_pkg::OPCLASS_IV;
            2'd1:    return valu_op_pkg::OPCLASS_IX;
            default: return valu_op_pkg::OPCLASS_IVI;
        endcase
    endfunction

    function automatic valu_types_pkg::data_t fill_elems(input int s, input logic [63:0] v);
        valu_types_pkg::data_t d;
        int                    i;
        d = '0;
        for (i = 0; i < 64 >> (3 + s); i++) begin
            d = d | (v << (i * (8 << s)));
        end
        return d;
    endfunction

    task automatic send_beat(input valu_types_pkg::funct_t f, input valu_types_pkg::opclass_t oc,
                             input valu_types_pkg::sew_t s, input logic st, input logic en,
                             input valu_types_pkg::data_t d0, input valu_types_pkg::data_t d1);
        valu_types_pkg::valu_req_t  r;
        valu_types_pkg::valu_resp_t e;
        logic [63:0]                v;
        rand_bits(40, v);
        r = '{funct: f, opclass: oc, sew: s, data0: d0, data1: d1, be: v[7:0],
              addr: v[39:8], is_start: st, is_end: en};
        @(posedge clk);
        #1;
        req       = r;
        req_valid = 1'b1;
        if (valu_ref(r, ref_acc, e)) begin
            exp_q.push_back(e);
            cyc_q.push_back(cyc + 3);   // three register stages
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic end_test(input string name);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 8) begin
            idle_cycle();
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("test %s: %0d expected responses never arrived", name, exp_q.size());
            errors += exp_q.size();
            exp_q.delete();
            cyc_q.delete();
        end
        repeat (2) idle_cycle();
        tests_run++;
        $display("test %0d %s finished with %0d errors", tests_run, name, errors - test_err0);
        test_err0 = errors;
    endtask

    initial begin
        int          s;
        int          j;
        int          k;
        logic [63:0] v;
        logic [63:0] d0;
        logic [63:0] d1;
        logic [63:0] sg;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_val("resp_valid", resp_valid, 1'b0);
        check_val("resp", resp, '0);
        end_test("reset");

        for (s = 0; s < 4; s++) begin
            for (j = 0; j < 8; j++) begin
                rand_bits(64, d0);
                rand_bits(64, d1);
                rand_bits(4, v);
                send_beat(j[0] ? valu_op_pkg::F_SUB : valu_op_pkg::F_ADD, elem_class(v[1:0]),
                          valu_types_pkg::sew_t'(s), v[2], v[3], d0, d1);
            end
        end
        end_test("add_sub");

        // extremes, then pairs differing only in the sign bit, then random
        for (s = 0; s < 4; s++) begin
            sg = 64'd1 << ((8 << s) - 1);
            for (k = 0; k < 4; k++) begin
                send_beat(mm_functs[k], valu_op_pkg::OPCLASS_IV, valu_types_pkg::sew_t'(s),
                          1'b0, 1'b0, fill_elems(s, sg - 64'd1), fill_elems(s, sg));
                rand_bits(64, d1);
                send_beat(mm_functs[k], valu_op_pkg::OPCLASS_IX, valu_types_pkg::sew_t'(s),
                          1'b1, 1'b0, d1 ^ fill_elems(s, sg), d1);
                rand_bits(64, d0);
                rand_bits(64, d1);
                send_beat(mm_functs[k], valu_op_pkg::OPCLASS_IVI, valu_types_pkg::sew_t'(s),
                          1'b0, 1'b1, d0, d1);
            end
        end
        end_test("min_max");

        for (j = 0; j < 32; j++) begin
            rand_bits(64, d0);
            rand_bits(64, d1);
            rand_bits(6, v);
            send_beat(lg_functs[j % 3], elem_class(v[1:0]), valu_types_pkg::sew_t'(v[3:2]),
                      v[4], v[5], d0, d1);
        end
        end_test("logic_back_to_back");

        // lengths 1 to 4 beats
        for (k = 0; k < 4; k++) begin
            for (s = 0; s < 4; s++) begin
                for (j = 0; j <= (k + s) % 4; j++) begin
                    rand_bits(64, d0);
                    rand_bits(64, d1);
                    send_beat(red_functs[k], valu_op_pkg::OPCLASS_MV, valu_types_pkg::sew_t'(s),
                              j == 0, j == (k + s) % 4, d0, d1);
                end
            end
        end
        end_test("reductions");

        for (k = 0; k < 2; k++) begin
            for (j = 0; j < 4; j++) begin
                rand_bits(64, d0);
                rand_bits(64, d1);
                send_beat(red_functs[k * 3], valu_op_pkg::OPCLASS_MV,
                          valu_types_pkg::sew_t'(k + 1), j == 0, j == 3, d0, d1);
                rand_bits(64, d0);
                rand_bits(64, d1);
                rand_bits(6, v);
                send_beat(j[0] ? valu_op_pkg::F_MAX : valu_op_pkg::F_ADD, elem_class(v[1:0]),
                          valu_types_pkg::sew_t'(v[3:2]), v[4], v[5], d0, d1);
            end
        end
        end_test("mixed");

        for (j = 0; j < 20; j++) begin
            rand_bits(64, d0);
            rand_bits(64, d1);
            rand_bits(6, v);
            if (j < 8) begin
                send_beat(bad_functs[j], elem_class(v[1:0]), valu_types_pkg::sew_t'(v[3:2]),
                          v[4], v[5], d0, d1);
            end else if (j < 16) begin
                // element codes 4 to 11 under MV
                send_beat(valu_types_pkg::funct_t'(j - 4), valu_op_pkg::OPCLASS_MV,
                          valu_types_pkg::sew_t'(v[3:2]), 1'b1, 1'b1, d0, d1);
            end else begin
                send_beat(valu_op_pkg::F_ADD, bad_classes[j - 16],
                          valu_types_pkg::sew_t'(v[3:2]), v[4], v[5], d0, d1);
            end
        end
        end_test("unsupported");

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+testbench
common/valu_types_pkg.sv
common/valu_op_pkg.sv
rtl/valu_decode.sv
alu/valu_elem_alu.sv
reduce/valu_red_accum.sv
rtl/valu_writeback.sv
rtl/valu_top.sv
testbench/tb_valu.sv

/* Makefile */
TOP = tb_valu

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee run.log
	grep -q "all tests passed" run.log

clean:
	rm -rf obj_dir run.log
